// ==== compile.f ====
+incdir+common
common/alu_pkg.sv
hw/instr_decode.sv
hw/op_queue.sv
exec/alu.sv
exec/exec_unit.sv
hw/alu_subsystem.sv
tb/tb_alu_subsystem.sv

// ==== Bender.yml ====
package:
  name: alu_subsystem

export_include_dirs:
  - common

sources:
  - files:
      - common/alu_pkg.sv
      - hw/instr_decode.sv
      - hw/op_queue.sv
      - exec/alu.sv
      - exec/exec_unit.sv
      - hw/alu_subsystem.sv
  - target: test
    files:
      - tb/tb_alu_subsystem.sv

// ==== tb/tb_alu_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module tb_alu_subsystem;
	import alu_pkg::*;

	localparam int DEPTH       = `ALU_QUEUE_DEPTH;
	localparam int N_RANDOM    = 400;
	localparam int N_BURSTS    = 16;
	localparam int N_TOTAL     = 4 + N_RANDOM + 10 + 7 + N_BURSTS * 7 + DEPTH + 3;
	localparam int TIMEOUT_CYC = 4 * N_TOTAL + 200;

	logic       clk;
	logic       arst_n;
	logic       instr_valid;
	instr_t     instr;
	logic       hold;
	logic       wb_valid;
	reg_idx_t   wb_dst;
	data_t      wb_data;
	logic       wb_wr;
	alu_flags_t flags;
	logic       overflow;

	logic [31:0] lfsr = 32'he2e266ff;
	instr_t      exp_q[$]; // accepted ops in issue order
	data_t       model_regs [`ALU_NUM_REGS];
	alu_flags_t  model_flags;
	bit          op_seen [16];
	int          errors, checks, tests, wb_count, cycles;

	alu_subsystem dut (
		.clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr), .hold(hold),
		.wb_valid(wb_valid), .wb_dst(wb_dst), .wb_data(wb_data), .wb_wr(wb_wr),
		.flags(flags), .overflow(overflow)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic instr_t make_instr(input alu_op_e op, input logic use_imm,
			input reg_idx_t dst, input reg_idx_t src, input data_t imm);
		instr_t i;
		i.opcode  = op;
		i.use_imm = use_imm;
		i.dst     = dst;
		i.src     = src;
		i.imm     = imm;
		return i;
	endfunction

	function automatic instr_t rand_instr();
		logic [31:0] r;
		r = rand_bits(17);
		return make_instr(alu_op_e'(r[16:13]), r[12], r[11:10], r[9:8], r[7:0]);
	endfunction

	// flags not listed for an op keep their value
	task automatic apply_model(input instr_t ins, output data_t res, output logic wr);
		data_t a, b;
		logic  cin;
		int    s;
		a = model_regs[ins.dst];
		b = ins.use_imm ? ins.imm : model_regs[ins.src];
		cin = model_flags.c;
		res = '0;
		case (ins.opcode)
			ALU_PASS_B: res = b;
			ALU_PASS_A: res = a;
			ALU_INC_A:  res = a + 8'd1;
			ALU_ADD: begin
				s = $signed(a) + $signed(b);
				res = a + b;
				model_flags.c = (int'(a) + int'(b)) > 255;
				model_flags.v = (s > 127) || (s < -128);
			end
			ALU_SUB: begin
				s = $signed(a) - $signed(b);
				res = a - b;
				model_flags.c = a < b; // borrow
				model_flags.v = (s > 127) || (s < -128);
			end
			ALU_AND: res = a & b;
			ALU_OR:  res = a | b;
			ALU_NOT: res = ~b;
			ALU_NEG: res = 8'd0 - b;
			ALU_RLC: begin
				res = {b[6:0], cin};
				model_flags.c = b[7];
			end
			ALU_RRC: begin
				res = {cin, b[7:1]};
				model_flags.c = b[0];
			end
			ALU_INC: begin
				res = b + 8'd1;
				model_flags.v = (b == 8'h7f);
				model_flags.c = (b == 8'hff);
			end
			ALU_DEC: begin
				res = b - 8'd1;
				model_flags.v = (b == 8'h80);
				model_flags.c = (b == 8'h00);
			end
			ALU_SETC: model_flags.c = 1'b1;
			ALU_CLRC: model_flags.c = 1'b0;
			default: ;
		endcase
		if (ins.opcode inside {ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC, ALU_AND, ALU_OR,
				ALU_NOT, ALU_NEG}) begin
			model_flags.z = (res == 8'h00);
			model_flags.n = res[7];
		end
		wr = !(ins.opcode inside {ALU_NOP, ALU_SETC, ALU_CLRC});
		if (wr) model_regs[ins.dst] = res;
	endtask

	task automatic report_fail(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check_writeback();
		instr_t ins;
		data_t  res;
		logic   wr;
		wb_count++;
		if (exp_q.size() == 0) begin
			$display("a result came out at %0t ns with no instruction outstanding", $time);
			errors++;
		end else begin
			ins = exp_q.pop_front();
			apply_model(ins, res, wr);
			checks++;
			if (wb_dst !== ins.dst)
				report_fail($sformatf("%s wb_dst %0d, expected %0d",
					ins.opcode.name(), wb_dst, ins.dst));
			if (wb_wr !== wr)
				report_fail($sformatf("%s wb_wr %b, expected %b",
					ins.opcode.name(), wb_wr, wr));
			if (wb_data !== res)
				report_fail($sformatf("%s wb_data %h, expected %h",
					ins.opcode.name(), wb_data, res));
			if (flags !== model_flags)
				report_fail($sformatf("%s flags %b, expected %b",
					ins.opcode.name(), flags, model_flags));
		end
	endtask

	always @(negedge clk) begin
		if (arst_n && wb_valid) check_writeback(); // outputs settled mid-cycle
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("run timed out after %0d cycles with results still missing", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic issue(input instr_t ins, input bit accept);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= ins;
		if (accept) exp_q.push_back(ins);
	endtask

	task automatic stop_issue();
		@(posedge clk);
		instr_valid <= 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) @(posedge clk);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		$display("%s done, %0d errors", name, errors - err_before);
	endtask

	task automatic corner(input alu_op_e op, input data_t a_val, input data_t b_val,
			input data_t exp, input alu_flags_t want);
		issue(make_instr(ALU_PASS_B, 1'b1, 2'd0, 2'd0, a_val), 1'b1);
		issue(make_instr(op, 1'b1, 2'd0, 2'd0, b_val), 1'b1);
		stop_issue();
		drain();
		checks++;
		if (wb_data !== exp || (flags & want) !== want)
			report_fail($sformatf("%s corner gave %h flags %b",
				op.name(), wb_data, flags));
	endtask

	initial begin
		int e0, w0, len;
		instr_t ins;
		clk = 1'b0;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		hold = 1'b0;
		model_flags = '0;
		for (int i = 0; i < `ALU_NUM_REGS; i++) model_regs[i] = '0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		e0 = errors;
		@(negedge clk);
		checks++;
		if (wb_valid !== 1'b0 || overflow !== 1'b0 || flags !== 4'b0000)
			report_fail($sformatf("after reset wb_valid %b overflow %b flags %b",
				wb_valid, overflow, flags));
		issue(make_instr(ALU_ADD, 1'b0, 2'd0, 2'd1, 8'h5a), 1'b1);
		issue(make_instr(ALU_OR, 1'b0, 2'd1, 2'd2, 8'h33), 1'b1);
		issue(make_instr(ALU_SUB, 1'b0, 2'd2, 2'd3, 8'hc3), 1'b1);
		issue(make_instr(ALU_PASS_A, 1'b0, 2'd3, 2'd0, 8'h11), 1'b1);
		stop_issue();
		drain();
		end_test("reset state", e0);

		e0 = errors;
		for (int k = 0; k < N_RANDOM; k++) begin
			ins = rand_instr();
			op_seen[ins.opcode] = 1'b1;
			issue(ins, 1'b1);
		end
		stop_issue();
		drain();
		foreach (op_seen[i]) begin
			if (!op_seen[i]) begin
				$display("random run never produced opcode %0d", i);
				errors++;
			end
		end
		end_test("random ops", e0);

		e0 = errors;
		corner(ALU_ADD, 8'h7f, 8'h01, 8'h80, '{z: 0, n: 1, c: 0, v: 1});
		corner(ALU_SUB, 8'h00, 8'h01, 8'hff, '{z: 0, n: 1, c: 1, v: 0});
		corner(ALU_INC, 8'h00, 8'hff, 8'h00, '{z: 1, n: 0, c: 1, v: 0});
		corner(ALU_DEC, 8'h00, 8'h00, 8'hff, '{z: 0, n: 1, c: 1, v: 0});
		corner(ALU_NEG, 8'h00, 8'h80, 8'h80, '{z: 0, n: 1, c: 0, v: 0});
		end_test("flag corners", e0);

		e0 = errors;
		issue(make_instr(ALU_SETC, 1'b0, 2'd1, 2'd2, 8'h00), 1'b1);
		issue(make_instr(ALU_CLRC, 1'b1, 2'd2, 2'd3, 8'hff), 1'b1);
		issue(make_instr(ALU_NOP, 1'b1, 2'd3, 2'd0, 8'h42), 1'b1);
		for (int r = 0; r < `ALU_NUM_REGS; r++)
			issue(make_instr(ALU_PASS_A, 1'b0, r[1:0], 2'd0, 8'h00), 1'b1); // readback
		stop_issue();
		drain();
		end_test("flag-only ops", e0);

		e0 = errors;
		for (int k = 0; k < N_BURSTS; k++) begin
			len = rand_bits(3) % 7 + 1; // always below the queue depth
			for (int j = 0; j < len; j++) begin
				issue(rand_instr(), 1'b1);
				hold <= (rand_bits(1) != 0);
			end
			stop_issue();
			hold <= 1'b0;
			drain();
		end
		checks++;
		if (overflow !== 1'b0) report_fail("overflow set during short bursts");
		end_test("held bursts", e0);

		e0 = errors;
		w0 = wb_count;
		@(posedge clk);
		hold <= 1'b1;
		for (int k = 0; k < DEPTH + 3; k++) issue(rand_instr(), k < DEPTH); // last three drop
		stop_issue();
		repeat (4) @(posedge clk);
		if (wb_count != w0) begin
			$display("results came out while hold was high");
			errors++;
		end
		hold <= 1'b0;
		drain();
		repeat (10) @(posedge clk);
		checks++;
		if (wb_count - w0 != DEPTH)
			report_fail($sformatf("%0d results after overfill, expected %0d",
				wb_count - w0, DEPTH));
		if (overflow !== 1'b1) report_fail("overflow not held high after overfill");
		end_test("overfill", e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/alu_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_subsystem (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  instr_valid,
	input  wire alu_pkg::instr_t instr,
	input  wire                  hold,
	output logic                 wb_valid,
	output alu_pkg::reg_idx_t    wb_dst,
	output alu_pkg::data_t       wb_data,
	output logic                 wb_wr,
	output alu_pkg::alu_flags_t  flags,
	output logic                 overflow
);
	import alu_pkg::*;

	logic    dec_valid;
	dec_op_t dec_op;
	logic    q_empty;
	dec_op_t q_op;
	logic    q_pop;

	instr_decode u_decode (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec_valid   (dec_valid),
		.dec_op      (dec_op)
	);

	op_queue #(
		.payload_t (dec_op_t),
		.DEPTH     (`ALU_QUEUE_DEPTH)
	) u_queue (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (dec_valid), // no back-pressure
		.push_data (dec_op),
		.pop       (q_pop),
		.empty     (q_empty),
		.head      (q_op),
		.overflow  (overflow)
	);

	exec_unit u_exec (
		.clk      (clk),
		.arst_n   (arst_n),
		.hold     (hold),
		.q_empty  (q_empty),
		.q_op     (q_op),
		.q_pop    (q_pop),
		.wb_valid (wb_valid),
		.wb_wr    (wb_wr),
		.wb_dst   (wb_dst),
		.wb_data  (wb_data),
		.flags    (flags)
	);

endmodule

`default_nettype wire

// ==== exec/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module exec_unit (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   hold,
	input  wire                   q_empty,
	input  wire alu_pkg::dec_op_t q_op,
	output logic                  q_pop,
	output logic                  wb_valid,
	output logic                  wb_wr,
	output alu_pkg::reg_idx_t     wb_dst,
	output alu_pkg::data_t        wb_data,
	output alu_pkg::alu_flags_t   flags
);
	import alu_pkg::*;

	data_t      regs [`ALU_NUM_REGS];
	data_t      op_a;
	data_t      op_b;
	data_t      alu_res;
	alu_flags_t alu_flags;

	assign q_pop = !q_empty && !hold; // one op per cycle unless held

	assign op_a = regs[q_op.ins.dst];
	assign op_b = q_op.ins.use_imm ? q_op.ins.imm : regs[q_op.ins.src];

	alu u_alu (
		.a         (op_a),
		.b         (op_b),
		.sel       (q_op.ins.opcode),
		.cin       (flags.c),
		.result    (alu_res),
		.flags_new (alu_flags)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ALU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			flags    <= '0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= q_pop;
			if (q_pop) begin
				if (q_op.wr_en) begin
					regs[q_op.ins.dst] <= alu_res;
				end
				// masked flags take the new value, others hold
				flags <= (alu_flags & q_op.flag_mask) | (flags & ~q_op.flag_mask);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop) begin
			wb_wr   <= q_op.wr_en;
			wb_dst  <= q_op.ins.dst;
			wb_data <= alu_res;
		end
	end

	a_wb_valid_known: assert property (@(posedge clk) arst_n |-> !$isunknown(wb_valid))
		else $error("wb_valid unknown out of reset");

endmodule

`default_nettype wire

// ==== exec/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu (
	input  wire [`ALU_DATA_W-1:0] a,
	input  wire [`ALU_DATA_W-1:0] b,
	input  wire alu_pkg::alu_op_e sel,
	input  wire                   cin,
	output logic [`ALU_DATA_W-1:0] result,
	output alu_pkg::alu_flags_t   flags_new
);
	import alu_pkg::*;

	localparam int W = `ALU_DATA_W;
	localparam logic [W-1:0] MAX_POS = {1'b0, {(W-1){1'b1}}}; // 7f
	localparam logic [W-1:0] MIN_NEG = {1'b1, {(W-1){1'b0}}}; // 80

	logic [W:0] wide; // add/sub with carry out

	always_comb begin
		result    = '0;
		flags_new = '0;
		wide      = '0;
		case (sel)
			ALU_PASS_B: result = b;
			ALU_PASS_A: result = a;
			ALU_INC_A:  result = a + 1'b1;
			ALU_ADD: begin
				wide        = {1'b0, a} + {1'b0, b};
				result      = wide[W-1:0];
				flags_new.c = wide[W];
				flags_new.v = (a[W-1] == b[W-1]) && (result[W-1] != a[W-1]);
			end
			ALU_SUB: begin
				wide        = {1'b0, a} - {1'b0, b};
				result      = wide[W-1:0];
				flags_new.c = wide[W]; // borrow
				flags_new.v = (a[W-1] != b[W-1]) && (result[W-1] != a[W-1]);
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_RLC: begin
				result      = {b[W-2:0], cin};
				flags_new.c = b[W-1];
			end
			ALU_RRC: begin
				result      = {cin, b[W-1:1]};
				flags_new.c = b[0];
			end
			ALU_NOT: result = ~b;
			ALU_NEG: result = -b;
			ALU_INC: begin
				result      = b + 1'b1;
				flags_new.v = (b == MAX_POS);
				flags_new.c = (b == '1);
			end
			ALU_DEC: begin
				result      = b - 1'b1;
				flags_new.v = (b == MIN_NEG);
				flags_new.c = (b == '0);
			end
			ALU_SETC: flags_new.c = 1'b1;
			ALU_CLRC: flags_new.c = 1'b0;
			default: ; // nop
		endcase

		// zero and sign come from the result for every op that reports them
		if (sel inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
				ALU_NOT, ALU_NEG, ALU_INC, ALU_DEC}) begin
			flags_new.z = (result == '0);
			flags_new.n = result[W-1];
		end
	end

endmodule

`default_nettype wire

// ==== hw/op_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_queue #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 8
) (
	input  wire           clk,
	input  wire           arst_n,
	input  wire           push,
	input  wire payload_t push_data,
	input  wire           pop,
	output logic          empty,
	output payload_t      head,
	output logic          overflow
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == (PTR_W+1)'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full; // push into a full queue is lost
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
			if (push && full) begin
				overflow <= 1'b1; // sticky until reset
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// the consumer gates its pop with empty
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> !empty)
		else $error("op_queue popped while empty");

endmodule

`default_nettype wire

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  instr_valid,
	input  wire alu_pkg::instr_t instr,
	output logic                 dec_valid,
	output alu_pkg::dec_op_t     dec_op
);
	import alu_pkg::*;

	alu_flags_t mask;
	logic       wr_en;

	// which flags each opcode is allowed to touch
	always_comb begin
		case (instr.opcode)
			ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC:
				mask = '{z: 1'b1, n: 1'b1, c: 1'b1, v: 1'b1};
			ALU_AND, ALU_OR, ALU_NOT, ALU_NEG:
				mask = '{z: 1'b1, n: 1'b1, c: 1'b0, v: 1'b0};
			ALU_RLC, ALU_RRC, ALU_SETC, ALU_CLRC:
				mask = '{z: 1'b0, n: 1'b0, c: 1'b1, v: 1'b0};
			default:
				mask = '0; // pass ops and nop
		endcase
	end

	// flag-only ops and nop leave the register file alone
	assign wr_en = !(instr.opcode inside {ALU_NOP, ALU_SETC, ALU_CLRC});

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_op.ins       <= instr;
			dec_op.wr_en     <= wr_en;
			dec_op.flag_mask <= mask;
		end
	end

endmodule

`default_nettype wire

// ==== common/alu_pkg.sv ====
`default_nettype none

`include "alu_config.svh"

package alu_pkg;

	typedef logic [`ALU_DATA_W-1:0] data_t;
	typedef logic [$clog2(`ALU_NUM_REGS)-1:0] reg_idx_t;

	// 4-bit opcode encodings
	typedef enum logic [3:0] {
		ALU_NOP    = 4'b0000,
		ALU_PASS_B = 4'b0001, // mov
		ALU_ADD    = 4'b0010,
		ALU_SUB    = 4'b0011,
		ALU_AND    = 4'b0100,
		ALU_OR     = 4'b0101,
		ALU_RLC    = 4'b0110,
		ALU_RRC    = 4'b0111,
		ALU_NOT    = 4'b1000,
		ALU_NEG    = 4'b1001,
		ALU_INC    = 4'b1010,
		ALU_DEC    = 4'b1011,
		ALU_SETC   = 4'b1100,
		ALU_CLRC   = 4'b1101,
		ALU_PASS_A = 4'b1110, // stack address path
		ALU_INC_A  = 4'b1111
	} alu_op_e;

	// also used as the per-op update mask
	typedef struct packed {
		logic z;
		logic n;
		logic c;
		logic v;
	} alu_flags_t;

	typedef struct packed {
		alu_op_e  opcode;
		logic     use_imm; // b from imm instead of src
		reg_idx_t dst;     // operand a and destination
		reg_idx_t src;
		data_t    imm;
	} instr_t;

	typedef struct packed {
		instr_t     ins;
		logic       wr_en;
		alu_flags_t flag_mask;
	} dec_op_t;

endpackage

`default_nettype wire

// ==== common/alu_config.svh ====
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// sizing of the execute slice

`define ALU_DATA_W      8 // operand and register width

`define ALU_NUM_REGS    4 // register file entries

`define ALU_QUEUE_DEPTH 8 // decoded ops buffered ahead of execute

`endif
